// File: bankedRam.f
+incdir+include
hw/bankedRamPkg.sv
hw/bankScheduler.sv
hw/writeRouter.sv
hw/readRouter.sv
hw/blockBank.sv
hw/bankedRam.sv
tb/bankedRamTb.sv

// File: hw/bankScheduler.sv
/*
 * Bank scheduler
 * Grants each bank to the lowest-numbered write and read port addressing it
 * and registers the collision flags
 */

`timescale 1ns/1ns
`default_nettype none

`include "bankedRam_config.svh"

module bankScheduler import bankedRamPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  WriteReq  writeReq[`BR_WRITE_NUM],
    input  BrAddr    readAddr[`BR_READ_NUM],
    output BankGrant writeGrant[`BR_BANK_NUM],
    output BankGrant readGrant[`BR_BANK_NUM],
    output logic     writeConflict,
    output logic     readConflict
);

    logic writeClash;
    logic readClash;

    // Scan from the highest port down so the lowest matching port is left standing
    always_comb begin
        for (int b = 0; b < `BR_BANK_NUM; b++) begin
            writeGrant[b] = '0;
            for (int p = `BR_WRITE_NUM - 1; p >= 0; p--) begin
                if (writeReq[p].we && bankOf(writeReq[p].addr) == BrBank'(b)) begin
                    writeGrant[b].valid = 1'b1;
                    writeGrant[b].port = BrPort'(p);
                end
            end

            // Reads have no enable, every port requests every cycle
            readGrant[b] = '0;
            for (int p = `BR_READ_NUM - 1; p >= 0; p--) begin
                if (bankOf(readAddr[p]) == BrBank'(b)) begin
                    readGrant[b].valid = 1'b1;
                    readGrant[b].port = BrPort'(p);
                end
            end
        end
    end

    // Any pair of ports landing on one bank is a collision
    always_comb begin
        writeClash = 1'b0;
        for (int i = 0; i < `BR_WRITE_NUM; i++) begin
            for (int j = i + 1; j < `BR_WRITE_NUM; j++) begin
                if (writeReq[i].we && writeReq[j].we &&
                    bankOf(writeReq[i].addr) == bankOf(writeReq[j].addr)) begin
                    writeClash = 1'b1;
                end
            end
        end

        readClash = 1'b0;
        for (int i = 0; i < `BR_READ_NUM; i++) begin
            for (int j = i + 1; j < `BR_READ_NUM; j++) begin
                if (bankOf(readAddr[i]) == bankOf(readAddr[j])) begin
                    readClash = 1'b1;
                end
            end
        end
    end

    // One flag cycle per colliding request cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            writeConflict <= 1'b0;
            readConflict <= 1'b0;
        end else begin
            writeConflict <= writeClash;
            readConflict <= readClash;
        end
    end

endmodule

`default_nettype wire

// File: hw/bankedRam.sv
/*
 * Banked block RAM top level
 * Scheduler, write and read routers and the interleaved banks
 */

`timescale 1ns/1ns
`default_nettype none

`include "bankedRam_config.svh"

module bankedRam import bankedRamPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  WriteReq writeReq[`BR_WRITE_NUM],
    input  BrAddr   readAddr[`BR_READ_NUM],
    output BrValue  readValue[`BR_READ_NUM],
    output logic    writeConflict,
    output logic    readConflict
);

    BankGrant writeGrant[`BR_BANK_NUM];
    BankGrant readGrant[`BR_BANK_NUM];
    BankWrite bankWrite[`BR_BANK_NUM];
    BrRow     bankReadRow[`BR_BANK_NUM];
    BrValue   bankReadValue[`BR_BANK_NUM];

    bankScheduler scheduler (
        .clk           (clk),
        .rst           (rst),
        .writeReq      (writeReq),
        .readAddr      (readAddr),
        .writeGrant    (writeGrant),
        .readGrant     (readGrant),
        .writeConflict (writeConflict),
        .readConflict  (readConflict)
    );

    writeRouter wrRouter (
        .writeReq   (writeReq),
        .writeGrant (writeGrant),
        .bankWrite  (bankWrite)
    );

    readRouter rdRouter (
        .clk           (clk),
        .readAddr      (readAddr),
        .readGrant     (readGrant),
        .bankReadRow   (bankReadRow),
        .bankReadValue (bankReadValue),
        .readValue     (readValue)
    );

    // Bank b holds the entries whose low address bits equal b
    for (genvar b = 0; b < `BR_BANK_NUM; b++) begin : genBank
        blockBank bank (
            .clk       (clk),
            .bankWrite (bankWrite[b]),
            .readRow   (bankReadRow[b]),
            .readValue (bankReadValue[b])
        );
    end

endmodule

`default_nettype wire

// File: hw/bankedRamPkg.sv
/*
 * Shared types of the banked block RAM
 * Address, row, value, request and grant types, plus address slicing helpers
 */

`default_nettype none

`include "bankedRam_config.svh"

package bankedRamPkg;

    localparam int ADDR_BITS = $clog2(`BR_ENTRY_NUM);
    localparam int BANK_BITS = $clog2(`BR_BANK_NUM);
    localparam int ROW_BITS = ADDR_BITS - BANK_BITS;
    localparam int MAX_PORTS = (`BR_READ_NUM > `BR_WRITE_NUM) ? `BR_READ_NUM : `BR_WRITE_NUM;
    localparam int PORT_BITS = (MAX_PORTS > 1) ? $clog2(MAX_PORTS) : 1;

    typedef logic [ADDR_BITS-1:0] BrAddr;
    typedef logic [BANK_BITS-1:0] BrBank;
    typedef logic [ROW_BITS-1:0] BrRow;
    typedef logic [`BR_ENTRY_BITS-1:0] BrValue;
    typedef logic [PORT_BITS-1:0] BrPort;

    typedef struct packed {
        logic we;
        BrAddr addr;
        BrValue value;
    } WriteReq;

    typedef struct packed {
        logic we;
        BrRow row;
        BrValue value;
    } BankWrite;

    typedef struct packed {
        logic valid;
        BrPort port;
    } BankGrant;

    // Banks are interleaved on the low address bits
    function automatic BrBank bankOf(input BrAddr addr);
        return addr[BANK_BITS-1:0];
    endfunction

    function automatic BrRow rowOf(input BrAddr addr);
        return addr[ADDR_BITS-1:BANK_BITS];
    endfunction

endpackage

`default_nettype wire

// File: hw/blockBank.sv
/*
 * One bank of the banked RAM
 * Simple dual-port block RAM, read-first, registered read output
 */

`timescale 1ns/1ns
`default_nettype none

`include "bankedRam_config.svh"

module blockBank import bankedRamPkg::*; (
    input  logic     clk,
    input  BankWrite bankWrite,
    input  BrRow     readRow,
    output BrValue   readValue
);

    localparam int DEPTH = `BR_ENTRY_NUM / `BR_BANK_NUM;

    BrValue mem[DEPTH];

    // Read and write share one block so a same-row read sees the old word
    always_ff @(posedge clk) begin
        readValue <= mem[readRow];
        if (bankWrite.we) begin
            mem[bankWrite.row] <= bankWrite.value;
        end
    end

endmodule

`default_nettype wire

// File: hw/readRouter.sv
/*
 * Read router
 * Steers granted read rows to the banks and returns bank data
 * to each read port one cycle later
 */

`timescale 1ns/1ns
`default_nettype none

`include "bankedRam_config.svh"

module readRouter import bankedRamPkg::*; (
    input  logic     clk,
    input  BrAddr    readAddr[`BR_READ_NUM],
    input  BankGrant readGrant[`BR_BANK_NUM],
    output BrRow     bankReadRow[`BR_BANK_NUM],
    input  BrValue   bankReadValue[`BR_BANK_NUM],
    output BrValue   readValue[`BR_READ_NUM]
);

    // Bank each port addressed in the previous cycle
    BrBank portBankQ[`BR_READ_NUM];

    // Row of the winning port, row 0 on an idle bank
    always_comb begin
        for (int b = 0; b < `BR_BANK_NUM; b++) begin
            if (readGrant[b].valid) begin
                bankReadRow[b] = rowOf(readAddr[readGrant[b].port]);
            end else begin
                bankReadRow[b] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < `BR_READ_NUM; p++) begin
            portBankQ[p] <= bankOf(readAddr[p]);
        end
    end

    // A losing port picks up whatever its bank read for the winner
    always_comb begin
        for (int p = 0; p < `BR_READ_NUM; p++) begin
            readValue[p] = bankReadValue[portBankQ[p]];
        end
    end

endmodule

`default_nettype wire

// File: hw/writeRouter.sv
/*
 * Write router
 * Places the granted write request of each bank on that bank's write port
 */

`timescale 1ns/1ns
`default_nettype none

`include "bankedRam_config.svh"

module writeRouter import bankedRamPkg::*; (
    input  WriteReq  writeReq[`BR_WRITE_NUM],
    input  BankGrant writeGrant[`BR_BANK_NUM],
    output BankWrite bankWrite[`BR_BANK_NUM]
);

    WriteReq chosen;

    always_comb begin
        for (int b = 0; b < `BR_BANK_NUM; b++) begin
            // Port field is zero without a grant, so data is port 0's and ignored
            chosen = writeReq[writeGrant[b].port];
            bankWrite[b].we = writeGrant[b].valid;
            bankWrite[b].row = rowOf(chosen.addr);
            bankWrite[b].value = chosen.value;
        end
    end

endmodule

`default_nettype wire

// File: include/bankedRam_config.svh
/*
 * Configuration macros for the banked block RAM
 * Entry count, entry width, port counts and bank count
 */

`ifndef BANKED_RAM_CONFIG_SVH
`define BANKED_RAM_CONFIG_SVH

// Total number of entries over all banks
`define BR_ENTRY_NUM 64
// Width of one stored word
`define BR_ENTRY_BITS 32

`define BR_READ_NUM 2
`define BR_WRITE_NUM 2

// Power of two, at least the larger port count, divides BR_ENTRY_NUM
`define BR_BANK_NUM 2

`endif

// File: tb/bankedRamTb.sv
/*
 * Testbench for the banked block RAM
 * Reference model with write priority, stimulus tests, assertions on
 * read data and conflict flags, watchdog and final report
 */

`timescale 1ns/1ns
`default_nettype none

`include "bankedRam_config.svh"

module bankedRamTb import bankedRamPkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_CYCLES = 500;
    // Reset, fill, directed tests and random traffic plus two flush cycles per test
    localparam int TEST_CYCLES = RESET_CYCLES + `BR_ENTRY_NUM + 40 + RANDOM_CYCLES + 12;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 200) * CLK_PERIOD;

    logic    clk;
    logic    rst;
    WriteReq writeReq[`BR_WRITE_NUM];
    BrAddr   readAddr[`BR_READ_NUM];
    BrValue  readValue[`BR_READ_NUM];
    logic    writeConflict;
    logic    readConflict;

    // Reference contents and which entries hold a known word
    logic [`BR_ENTRY_BITS-1:0] model[`BR_ENTRY_NUM];
    bit known[`BR_ENTRY_NUM];

    // Expectations for the cycle after the current edge
    logic [`BR_ENTRY_BITS-1:0] expRead[`BR_READ_NUM];
    bit expKnown[`BR_READ_NUM];
    logic expWriteConflict;
    logic expReadConflict;

    bit checkOn;
    int errCount;
    int markErr;
    int passCount;
    int failCount;

    bankedRam uut (
        .clk           (clk),
        .rst           (rst),
        .writeReq      (writeReq),
        .readAddr      (readAddr),
        .readValue     (readValue),
        .writeConflict (writeConflict),
        .readConflict  (readConflict)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Interleaving on the low address bits
    function automatic int bankNum(input logic [5:0] addr);
        return int'(addr) % `BR_BANK_NUM;
    endfunction

    function automatic WriteReq mkWrite(input logic we, input int addr,
                                        input logic [31:0] value);
        WriteReq w;
        w.we = we;
        w.addr = BrAddr'(addr);
        w.value = value;
        return w;
    endfunction

    function automatic logic [31:0] fillWord(input int addr);
        return (addr * 32'h9e3779b1) ^ 32'h5a5a0000 ^ addr;
    endfunction

    // Reference model applied at every edge on the inputs in place before it
    always @(posedge clk) begin : refModel
        bit taken[`BR_BANK_NUM];
        bit wClash;
        bit rClash;
        int win;
        wClash = 1'b0;
        rClash = 1'b0;
        // Reads see the contents before this cycle's writes
        for (int p = 0; p < `BR_READ_NUM; p++) begin
            win = p;
            for (int k = p - 1; k >= 0; k--) begin
                if (bankNum(readAddr[k]) == bankNum(readAddr[p])) begin
                    win = k;
                    rClash = 1'b1;
                end
            end
            expRead[p] <= model[readAddr[win]];
            expKnown[p] <= known[readAddr[win]];
        end
        for (int b = 0; b < `BR_BANK_NUM; b++) begin
            taken[b] = 1'b0;
        end
        // Lowest enabled write port owns its bank
        for (int w = 0; w < `BR_WRITE_NUM; w++) begin
            if (writeReq[w].we) begin
                if (taken[bankNum(writeReq[w].addr)]) begin
                    wClash = 1'b1;
                end else begin
                    taken[bankNum(writeReq[w].addr)] = 1'b1;
                    model[writeReq[w].addr] = writeReq[w].value;
                    known[writeReq[w].addr] = 1'b1;
                end
            end
        end
        expWriteConflict <= rst ? 1'b0 : wClash;
        expReadConflict <= rst ? 1'b0 : rClash;
    end

    // Outputs are stable by the falling edge
    always @(negedge clk) begin
        if (checkOn) begin
            for (int p = 0; p < `BR_READ_NUM; p++) begin
                if (expKnown[p]) begin
                    assert (readValue[p] === expRead[p]) else begin
                        errCount++;
                        $display("ERR t=%0t readValue[%0d] expected %h got %h",
                                 $time, p, expRead[p], readValue[p]);
                    end
                end
            end
            assert (writeConflict === expWriteConflict) else begin
                errCount++;
                $display("ERR t=%0t writeConflict expected %b got %b",
                         $time, expWriteConflict, writeConflict);
            end
            assert (readConflict === expReadConflict) else begin
                errCount++;
                $display("ERR t=%0t readConflict expected %b got %b",
                         $time, expReadConflict, readConflict);
            end
        end
    end

    task automatic drive(input WriteReq w0, input WriteReq w1, input int r0, input int r1);
        @(posedge clk);
        writeReq[0] <= w0;
        writeReq[1] <= w1;
        readAddr[0] <= BrAddr'(r0);
        readAddr[1] <= BrAddr'(r1);
    endtask

    // Reads on different banks so no flag rises
    task automatic idle();
        drive(mkWrite(0, 0, 0), mkWrite(0, 0, 0), 0, 1);
    endtask

    task automatic finishTest(input string name);
        idle();
        idle();
        if (errCount == markErr) begin
            passCount++;
            $display("test %s: PASS", name);
        end else begin
            failCount++;
            $display("test %s: FAIL with %0d errors", name, errCount - markErr);
        end
        markErr = errCount;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the tests did not finish in time");
        $display("sim failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h8f1c970d));
        clk = 1'b0;
        rst = 1'b1;
        checkOn = 1'b0;
        errCount = 0;
        markErr = 0;
        passCount = 0;
        failCount = 0;
        // Requests collide on bank 0 while reset holds both flags low
        for (int p = 0; p < `BR_WRITE_NUM; p++) begin
            writeReq[p] = mkWrite(1, 0, 0);
        end
        for (int p = 0; p < `BR_READ_NUM; p++) begin
            readAddr[p] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int p = 0; p < `BR_WRITE_NUM; p++) begin
            writeReq[p] <= mkWrite(0, 0, 0);
        end
        for (int p = 0; p < `BR_READ_NUM; p++) begin
            readAddr[p] <= BrAddr'(p);
        end
        checkOn = 1'b1;

        // Fill through port 0 alone with reads kept on separate banks
        for (int i = 0; i < `BR_ENTRY_NUM; i++) begin
            drive(mkWrite(1, i, fillWord(i)), mkWrite(0, 0, 0), i, i ^ 1);
        end
        finishTest("reset and fill");

        // Write and then read the same address at the next edge on each port
        drive(mkWrite(1, 5, 32'h1111_0005), mkWrite(0, 0, 0), 0, 1);
        drive(mkWrite(0, 0, 0), mkWrite(0, 0, 0), 5, 8);
        drive(mkWrite(1, 9, 32'h2222_0009), mkWrite(0, 0, 0), 0, 1);
        drive(mkWrite(0, 0, 0), mkWrite(0, 0, 0), 8, 9);
        finishTest("write then read");

        // Same-cycle read returns the old word and the next one the new word
        drive(mkWrite(1, 14, 32'h3333_000e), mkWrite(0, 0, 0), 14, 15);
        drive(mkWrite(0, 0, 0), mkWrite(0, 0, 0), 14, 15);
        drive(mkWrite(1, 17, 32'h4444_0011), mkWrite(0, 0, 0), 16, 17);
        drive(mkWrite(0, 0, 0), mkWrite(0, 0, 0), 16, 17);
        finishTest("read first");

        // Colliding writes keep port 0 while disjoint banks keep both
        drive(mkWrite(1, 10, 32'haaaa_000a), mkWrite(1, 12, 32'hbbbb_000c), 0, 1);
        drive(mkWrite(0, 0, 0), mkWrite(0, 0, 0), 10, 13);
        drive(mkWrite(0, 0, 0), mkWrite(0, 0, 0), 12, 13);
        drive(mkWrite(1, 20, 32'hcccc_0014), mkWrite(1, 21, 32'hdddd_0015), 0, 1);
        drive(mkWrite(0, 0, 0), mkWrite(0, 0, 0), 20, 21);
        finishTest("write conflict");

        // Port 1 loses the bank and gets port 0's word
        drive(mkWrite(0, 0, 0), mkWrite(0, 0, 0), 3, 7);
        drive(mkWrite(0, 0, 0), mkWrite(0, 0, 0), 2, 6);
        finishTest("read conflict");

        // Two banks make collisions frequent
        repeat (RANDOM_CYCLES) begin
            @(posedge clk);
            for (int p = 0; p < `BR_WRITE_NUM; p++) begin
                writeReq[p] <= mkWrite($urandom_range(0, 1), $urandom_range(0, 63), $urandom);
            end
            for (int p = 0; p < `BR_READ_NUM; p++) begin
                readAddr[p] <= BrAddr'($urandom_range(0, 63));
            end
        end
        finishTest("random traffic");

        $display("tests passed %0d, failed %0d, assertion errors %0d",
                 passCount, failCount, errCount);
        if (failCount == 0 && errCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
